// File: verilog/dma_pkg.sv
`default_nettype none

package dma_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int ADDR_W        = 32;
  localparam int DATA_W        = 32;
  localparam int LEVEL_W       = 5;
  localparam int TX_FIFO_DEPTH = 16;
  localparam int BURST_W       = 4;
  localparam int WORD_BYTES    = 4;

  // ------------------------------
  // Encodings
  // ------------------------------
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_RD,
    ST_RUN_RD,
    ST_WAIT_WR,
    ST_RUN_WR,
    ST_DONE
  } dma_state_e;

  // Per-word sequencing in the AXI movers
  typedef enum logic [1:0] {
    MV_IDLE,
    MV_ADDR,
    MV_DATA,
    MV_RESP
  } mover_state_e;

  typedef enum logic [0:0] {
    DIR_MEM_TO_TX = 1'b0,
    DIR_RX_TO_MEM = 1'b1
  } dma_dir_e;

endpackage

`default_nettype wire

// File: verilog/dma_burst_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dma_burst_if import dma_pkg::*; ();

  // Launch pulse from the controller
  logic              start;
  // Burst window from the counter held while the burst runs
  logic [ADDR_W-1:0] addr;
  logic [ADDR_W-1:0] len_bytes;
  logic              incr;
  // Completion and error pulses from the mover
  logic              done;
  logic              err;

  modport ctrl (output start, input done, input err);

  modport cnt (output addr, output len_bytes, output incr);

  modport mover (
    input  start, input addr, input len_bytes, input incr,
    output done, output err
  );

endinterface

`default_nettype wire

// File: verilog/dma_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_fsm import dma_pkg::*; (
  input  logic      clk,
  input  logic      resetn,
  input  logic      dma_en_i,
  input  dma_dir_e  dma_dir_i,
  input  logic      rem_zero_i,
  input  logic      tx_room_i,
  input  logic      rx_avail_i,
  input  logic      last_burst_i,
  output logic      load_o,
  output logic      latch_burst_o,
  output logic      advance_o,
  output logic      dma_done_o,
  output logic      axi_err_o,
  output logic      busy_o,
  dma_burst_if.ctrl rd_burst,
  dma_burst_if.ctrl wr_burst
);

  dma_state_e state;
  logic       en_q;
  logic       start_edge;
  logic       busy_r;
  logic       err_r;
  logic       done_r;
  logic       rd_go;
  logic       wr_go;
  logic       burst_done;
  logic       burst_err;
  logic       stop;

  // Enable edge detect
  always_ff @(posedge clk) begin
    if (!resetn) begin
      en_q <= 1'b0;
    end else begin
      en_q <= dma_en_i;
    end
  end

  assign start_edge = dma_en_i & ~en_q;

  // A burst goes out only once the FIFO can take or supply all of it
  assign rd_go = (state == ST_WAIT_RD) && !rem_zero_i && tx_room_i;
  assign wr_go = (state == ST_WAIT_WR) && !rem_zero_i && rx_avail_i;

  assign burst_done = ((state == ST_RUN_RD) && rd_burst.done) ||
                      ((state == ST_RUN_WR) && wr_burst.done);
  assign burst_err  = rd_burst.err | wr_burst.err;

  // Error may land together with the final done of a write burst
  assign stop = err_r | burst_err | last_burst_i;

  assign load_o         = (state == ST_IDLE) && start_edge;
  assign latch_burst_o  = rd_go | wr_go;
  assign advance_o      = burst_done;
  assign rd_burst.start = rd_go;
  assign wr_burst.start = wr_go;

  assign dma_done_o = done_r;
  assign axi_err_o  = err_r;
  assign busy_o     = busy_r & dma_en_i;

  // ------------------------------
  // Transfer sequencing
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state  <= ST_IDLE;
      busy_r <= 1'b0;
      err_r  <= 1'b0;
      done_r <= 1'b0;
    end else begin
      done_r <= (state == ST_DONE);
      if (!dma_en_i && !busy_r) begin
        state <= ST_IDLE;
        err_r <= 1'b0;
      end else begin
        if (burst_err) begin
          err_r <= 1'b1;
        end
        case (state)
          ST_IDLE: begin
            err_r <= 1'b0;
            if (start_edge) begin
              busy_r <= 1'b1;
              state  <= (dma_dir_i == DIR_RX_TO_MEM) ? ST_WAIT_WR : ST_WAIT_RD;
            end
          end
          ST_WAIT_RD: begin
            if (rem_zero_i) begin
              state <= ST_DONE;
            end else if (rd_go) begin
              state <= ST_RUN_RD;
            end
          end
          ST_RUN_RD: begin
            if (burst_done) begin
              state <= stop ? ST_DONE : ST_WAIT_RD;
            end
          end
          ST_WAIT_WR: begin
            if (rem_zero_i) begin
              state <= ST_DONE;
            end else if (wr_go) begin
              state <= ST_RUN_WR;
            end
          end
          ST_RUN_WR: begin
            if (burst_done) begin
              state <= stop ? ST_DONE : ST_WAIT_WR;
            end
          end
          ST_DONE: begin
            busy_r <= 1'b0;
            state  <= ST_IDLE;
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/dma_xfer_counter.sv
`timescale 1ns/1ps
`default_nettype none

module dma_xfer_counter import dma_pkg::*; (
  input  logic               clk,
  input  logic               resetn,
  input  logic               load_i,
  input  logic               latch_burst_i,
  input  logic               advance_i,
  input  logic [ADDR_W-1:0]  dma_addr_i,
  input  logic [ADDR_W-1:0]  dma_len_i,
  input  logic [BURST_W-1:0] burst_size_i,
  input  logic               incr_addr_i,
  input  logic [LEVEL_W-1:0] tx_level_i,
  input  logic [LEVEL_W-1:0] rx_level_i,
  output logic               rem_zero_o,
  output logic               tx_room_o,
  output logic               rx_avail_o,
  output logic               last_burst_o,
  dma_burst_if.cnt           rd_burst,
  dma_burst_if.cnt           wr_burst
);

  logic [ADDR_W-1:0]  addr_r;
  logic [ADDR_W-1:0]  rem_r;
  logic [ADDR_W-1:0]  len_r;
  logic [BURST_W-1:0] burst_size_r;
  logic               incr_r;

  logic [ADDR_W-1:0]  rem_words;
  logic [BURST_W-1:0] burst_words;
  logic [BURST_W-1:0] beats;
  logic [ADDR_W-1:0]  next_len;
  logic [LEVEL_W:0]   tx_sum;

  // Beats of the next burst where a burst size of 0 means one word
  assign rem_words   = rem_r / ADDR_W'(WORD_BYTES);
  assign burst_words = (burst_size_r == '0) ? BURST_W'(1) : burst_size_r;
  assign beats       = (rem_words < ADDR_W'(burst_words)) ? rem_words[BURST_W-1:0]
                                                          : burst_words;
  assign next_len    = ADDR_W'(beats) * ADDR_W'(WORD_BYTES);

  // FIFO level checks
  assign tx_sum       = (LEVEL_W+1)'(tx_level_i) + (LEVEL_W+1)'(beats);
  assign tx_room_o    = (tx_sum <= (LEVEL_W+1)'(TX_FIFO_DEPTH));
  assign rx_avail_o   = (rx_level_i >= LEVEL_W'(beats));
  assign rem_zero_o   = (rem_r == '0);
  assign last_burst_o = (rem_r <= len_r);

  assign rd_burst.addr      = addr_r;
  assign rd_burst.len_bytes = len_r;
  assign rd_burst.incr      = incr_r;
  assign wr_burst.addr      = addr_r;
  assign wr_burst.len_bytes = len_r;
  assign wr_burst.incr      = incr_r;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      addr_r       <= '0;
      rem_r        <= '0;
      len_r        <= '0;
      burst_size_r <= '0;
      incr_r       <= 1'b0;
    end else if (load_i) begin
      addr_r       <= dma_addr_i & ~ADDR_W'(WORD_BYTES - 1);
      rem_r        <= dma_len_i;
      len_r        <= '0;
      burst_size_r <= burst_size_i;
      incr_r       <= incr_addr_i;
    end else if (latch_burst_i) begin
      len_r <= next_len;
    end else if (advance_i) begin
      if (incr_r) begin
        addr_r <= addr_r + len_r;
      end
      rem_r <= (rem_r <= len_r) ? '0 : rem_r - len_r;
    end
  end

endmodule

`default_nettype wire

// File: verilog/axi_rd_mover.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rd_mover import dma_pkg::*; (
  input  logic              clk,
  input  logic              resetn,
  input  logic              arready_i,
  input  logic              rvalid_i,
  input  logic [DATA_W-1:0] rdata_i,
  input  logic [1:0]        rresp_i,
  input  logic              tx_full_i,
  output logic [ADDR_W-1:0] araddr_o,
  output logic              arvalid_o,
  output logic              rready_o,
  output logic [DATA_W-1:0] fifo_tx_data_o,
  output logic              fifo_tx_we_o,
  dma_burst_if.mover        burst
);

  mover_state_e      state;
  logic [ADDR_W-1:0] addr_r;
  logic [ADDR_W-1:0] cnt_r;
  logic [ADDR_W-1:0] cnt_next;
  logic [DATA_W-1:0] data_r;
  logic              arvalid_r;
  logic              we_r;
  logic              done_r;
  logic              err_r;
  logic              r_hs;

  // Full TX FIFO holds off R
  assign rready_o = (state == MV_DATA) && !tx_full_i;
  assign r_hs     = rvalid_i && rready_o;
  assign cnt_next = cnt_r + ADDR_W'(WORD_BYTES);

  assign araddr_o       = addr_r;
  assign arvalid_o      = arvalid_r;
  assign fifo_tx_data_o = data_r;
  assign fifo_tx_we_o   = we_r;
  assign burst.done     = done_r;
  assign burst.err      = err_r;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= MV_IDLE;
      cnt_r     <= '0;
      arvalid_r <= 1'b0;
      we_r      <= 1'b0;
      done_r    <= 1'b0;
      err_r     <= 1'b0;
    end else begin
      we_r   <= 1'b0;
      done_r <= 1'b0;
      err_r  <= 1'b0;
      case (state)
        MV_IDLE: begin
          if (burst.start) begin
            cnt_r     <= '0;
            arvalid_r <= 1'b1;
            state     <= MV_ADDR;
          end
        end
        MV_ADDR: begin
          if (arready_i) begin
            arvalid_r <= 1'b0;
            state     <= MV_DATA;
          end
        end
        MV_DATA: begin
          if (r_hs) begin
            we_r  <= 1'b1;
            err_r <= rresp_i[1];
            cnt_r <= cnt_next;
            if (cnt_next < burst.len_bytes) begin
              arvalid_r <= 1'b1;
              state     <= MV_ADDR;
            end else begin
              state <= MV_RESP;
            end
          end
        end
        MV_RESP: begin
          done_r <= 1'b1;
          state  <= MV_IDLE;
        end
        default: state <= MV_IDLE;
      endcase
    end
  end

  // Word address and read data
  always_ff @(posedge clk) begin
    if ((state == MV_IDLE) && burst.start) begin
      addr_r <= burst.addr;
    end else if (r_hs && burst.incr) begin
      addr_r <= addr_r + ADDR_W'(WORD_BYTES);
    end
    if (r_hs) begin
      data_r <= rdata_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/axi_wr_mover.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_mover import dma_pkg::*; (
  input  logic              clk,
  input  logic              resetn,
  input  logic              awready_i,
  input  logic              wready_i,
  input  logic              bvalid_i,
  input  logic [1:0]        bresp_i,
  input  logic [DATA_W-1:0] fifo_rx_data_i,
  output logic [ADDR_W-1:0] awaddr_o,
  output logic              awvalid_o,
  output logic [DATA_W-1:0] wdata_o,
  output logic              wvalid_o,
  output logic              bready_o,
  output logic              fifo_rx_re_o,
  dma_burst_if.mover        burst
);

  mover_state_e      state;
  logic [ADDR_W-1:0] addr_r;
  logic [ADDR_W-1:0] cnt_r;
  logic [ADDR_W-1:0] cnt_next;
  logic [DATA_W-1:0] wdata_r;
  logic              awvalid_r;
  logic              wvalid_r;
  logic              bready_r;
  logic              re_r;
  logic              wait_r;
  logic              capture;
  logic              b_hs;
  logic              done_r;
  logic              err_r;

  // RX data is valid the cycle after the read pulse
  assign capture  = (state == MV_DATA) && !wait_r && !re_r && !wvalid_r;
  assign b_hs     = bvalid_i && bready_r;
  assign cnt_next = cnt_r + ADDR_W'(WORD_BYTES);

  assign awaddr_o     = addr_r;
  assign awvalid_o    = awvalid_r;
  assign wdata_o      = wdata_r;
  assign wvalid_o     = wvalid_r;
  assign bready_o     = bready_r;
  assign fifo_rx_re_o = re_r;
  assign burst.done   = done_r;
  assign burst.err    = err_r;

  // ------------------------------
  // Per-word AW, FIFO read, W, B
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= MV_IDLE;
      cnt_r     <= '0;
      awvalid_r <= 1'b0;
      wvalid_r  <= 1'b0;
      bready_r  <= 1'b0;
      re_r      <= 1'b0;
      wait_r    <= 1'b0;
      done_r    <= 1'b0;
      err_r     <= 1'b0;
    end else begin
      re_r   <= 1'b0;
      done_r <= 1'b0;
      err_r  <= 1'b0;
      case (state)
        MV_IDLE: begin
          if (burst.start) begin
            cnt_r     <= '0;
            awvalid_r <= 1'b1;
            state     <= MV_ADDR;
          end
        end
        MV_ADDR: begin
          if (awready_i) begin
            awvalid_r <= 1'b0;
            re_r      <= 1'b1;
            wait_r    <= 1'b1;
            state     <= MV_DATA;
          end
        end
        MV_DATA: begin
          if (wait_r) begin
            wait_r <= 1'b0;
          end else if (capture) begin
            wvalid_r <= 1'b1;
          end else if (wvalid_r && wready_i) begin
            wvalid_r <= 1'b0;
            bready_r <= 1'b1;
            state    <= MV_RESP;
          end
        end
        MV_RESP: begin
          if (b_hs) begin
            bready_r <= 1'b0;
            err_r    <= bresp_i[1];
            cnt_r    <= cnt_next;
            if (cnt_next < burst.len_bytes) begin
              awvalid_r <= 1'b1;
              state     <= MV_ADDR;
            end else begin
              done_r <= 1'b1;
              state  <= MV_IDLE;
            end
          end
        end
        default: state <= MV_IDLE;
      endcase
    end
  end

  // Word address and captured W data
  always_ff @(posedge clk) begin
    if ((state == MV_IDLE) && burst.start) begin
      addr_r <= burst.addr;
    end else if (b_hs && burst.incr) begin
      addr_r <= addr_r + ADDR_W'(WORD_BYTES);
    end
    if (capture) begin
      wdata_r <= fifo_rx_data_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/dma_engine.sv
`timescale 1ns/1ps
`default_nettype none

module dma_engine import dma_pkg::*; (
  input  logic               clk,
  input  logic               resetn,
  // Configuration
  input  logic               dma_en_i,
  input  logic               dma_dir_i,
  input  logic [BURST_W-1:0] burst_size_i,
  input  logic               incr_addr_i,
  input  logic [ADDR_W-1:0]  dma_addr_i,
  input  logic [ADDR_W-1:0]  dma_len_i,
  // FIFOs
  input  logic [LEVEL_W-1:0] tx_level_i,
  output logic [DATA_W-1:0]  fifo_tx_data_o,
  output logic               fifo_tx_we_o,
  input  logic [LEVEL_W-1:0] rx_level_i,
  input  logic [DATA_W-1:0]  fifo_rx_data_i,
  output logic               fifo_rx_re_o,
  // Status
  output logic               dma_done_o,
  output logic               axi_err_o,
  output logic               busy_o,
  // AXI4-Lite write channels
  output logic [ADDR_W-1:0]  awaddr_o,
  output logic               awvalid_o,
  input  logic               awready_i,
  output logic [DATA_W-1:0]  wdata_o,
  output logic               wvalid_o,
  input  logic               wready_i,
  input  logic               bvalid_i,
  input  logic [1:0]         bresp_i,
  output logic               bready_o,
  // AXI4-Lite read channels
  output logic [ADDR_W-1:0]  araddr_o,
  output logic               arvalid_o,
  input  logic               arready_i,
  input  logic [DATA_W-1:0]  rdata_i,
  input  logic               rvalid_i,
  input  logic [1:0]         rresp_i,
  output logic               rready_o
);

  logic load;
  logic latch_burst;
  logic advance;
  logic rem_zero;
  logic tx_room;
  logic rx_avail;
  logic last_burst;
  logic tx_full;

  assign tx_full = (tx_level_i == LEVEL_W'(TX_FIFO_DEPTH));

  dma_burst_if rd_burst ();
  dma_burst_if wr_burst ();

  dma_ctrl_fsm u_ctrl (
    .clk           (clk),
    .resetn        (resetn),
    .dma_en_i      (dma_en_i),
    .dma_dir_i     (dma_dir_e'(dma_dir_i)),
    .rem_zero_i    (rem_zero),
    .tx_room_i     (tx_room),
    .rx_avail_i    (rx_avail),
    .last_burst_i  (last_burst),
    .load_o        (load),
    .latch_burst_o (latch_burst),
    .advance_o     (advance),
    .dma_done_o    (dma_done_o),
    .axi_err_o     (axi_err_o),
    .busy_o        (busy_o),
    .rd_burst      (rd_burst.ctrl),
    .wr_burst      (wr_burst.ctrl)
  );

  dma_xfer_counter u_counter (
    .clk           (clk),
    .resetn        (resetn),
    .load_i        (load),
    .latch_burst_i (latch_burst),
    .advance_i     (advance),
    .dma_addr_i    (dma_addr_i),
    .dma_len_i     (dma_len_i),
    .burst_size_i  (burst_size_i),
    .incr_addr_i   (incr_addr_i),
    .tx_level_i    (tx_level_i),
    .rx_level_i    (rx_level_i),
    .rem_zero_o    (rem_zero),
    .tx_room_o     (tx_room),
    .rx_avail_o    (rx_avail),
    .last_burst_o  (last_burst),
    .rd_burst      (rd_burst.cnt),
    .wr_burst      (wr_burst.cnt)
  );

  axi_rd_mover u_rd_mover (
    .clk            (clk),
    .resetn         (resetn),
    .arready_i      (arready_i),
    .rvalid_i       (rvalid_i),
    .rdata_i        (rdata_i),
    .rresp_i        (rresp_i),
    .tx_full_i      (tx_full),
    .araddr_o       (araddr_o),
    .arvalid_o      (arvalid_o),
    .rready_o       (rready_o),
    .fifo_tx_data_o (fifo_tx_data_o),
    .fifo_tx_we_o   (fifo_tx_we_o),
    .burst          (rd_burst.mover)
  );

  axi_wr_mover u_wr_mover (
    .clk            (clk),
    .resetn         (resetn),
    .awready_i      (awready_i),
    .wready_i       (wready_i),
    .bvalid_i       (bvalid_i),
    .bresp_i        (bresp_i),
    .fifo_rx_data_i (fifo_rx_data_i),
    .awaddr_o       (awaddr_o),
    .awvalid_o      (awvalid_o),
    .wdata_o        (wdata_o),
    .wvalid_o       (wvalid_o),
    .bready_o       (bready_o),
    .fifo_rx_re_o   (fifo_rx_re_o),
    .burst          (wr_burst.mover)
  );

endmodule

`default_nettype wire

// File: verification/tb_axi_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem import dma_pkg::*; (
  input  logic              clk,
  input  logic              resetn,
  input  logic              err_en_i,
  input  logic [ADDR_W-1:0] err_addr_i,
  input  logic [ADDR_W-1:0] awaddr_i,
  input  logic              awvalid_i,
  output logic              awready_o,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic              wvalid_i,
  output logic              wready_o,
  output logic              bvalid_o,
  output logic [1:0]        bresp_o,
  input  logic              bready_i,
  input  logic [ADDR_W-1:0] araddr_i,
  input  logic              arvalid_i,
  output logic              arready_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              rvalid_o,
  output logic [1:0]        rresp_o,
  input  logic              rready_i
);

  logic [DATA_W-1:0] mem [0:255];
  logic [ADDR_W-1:0] ar_addr_q;
  logic [ADDR_W-1:0] aw_addr_q;
  logic [DATA_W-1:0] w_data_q;
  logic              ar_hs, r_hs, aw_hs, w_hs, b_hs;
  logic [1:0]        rd_st, wr_st;
  logic [1:0]        rd_cnt, wr_cnt;

  // Preset pattern spreads every address bit over the word
  function automatic logic [31:0] preset_word(input logic [31:0] addr);
    return (addr * 32'h9e3779b1) ^ 32'h5a5ac3c3;
  endfunction

  initial begin
    {arready_o, rvalid_o, awready_o, wready_o, bvalid_o} = '0;
    {rresp_o, bresp_o} = '0;
    rdata_o = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = preset_word(32'(i) * 32'd4);
    end
  end

  // Handshakes seen on the rising edge
  always @(posedge clk) begin
    ar_hs <= arvalid_i && arready_o;
    r_hs  <= rvalid_o && rready_i;
    aw_hs <= awvalid_i && awready_o;
    w_hs  <= wvalid_i && wready_o;
    b_hs  <= bvalid_o && bready_i;
    if (arvalid_i && arready_o) ar_addr_q <= araddr_i;
    if (awvalid_i && awready_o) aw_addr_q <= awaddr_i;
    if (wvalid_i && wready_o) w_data_q <= wdata_i;
  end

  // ------------------------------
  // Slave responses on the falling edge
  // ------------------------------
  always @(negedge clk) begin
    if (!resetn) begin
      {arready_o, rvalid_o, awready_o, wready_o, bvalid_o} <= '0;
      {rresp_o, bresp_o, rd_st, wr_st, rd_cnt, wr_cnt} <= '0;
      rdata_o <= '0;
    end else begin
      case (rd_st)
        2'd0: begin
          if (ar_hs) begin
            arready_o <= 1'b0;
            rd_cnt    <= 2'($urandom % 3);
            rd_st     <= 2'd1;
          end else begin
            arready_o <= 1'($urandom % 2);
          end
        end
        2'd1: begin
          if (rd_cnt == 2'd0) begin
            rvalid_o <= 1'b1;
            rdata_o  <= mem[ar_addr_q[9:2]];
            rresp_o  <= (err_en_i && ar_addr_q == err_addr_i) ? 2'b10 : 2'b00;
            rd_st    <= 2'd2;
          end else begin
            rd_cnt <= rd_cnt - 2'd1;
          end
        end
        default: begin
          if (r_hs) begin
            rvalid_o <= 1'b0;
            rd_st    <= 2'd0;
          end
        end
      endcase
      case (wr_st)
        2'd0: begin
          if (aw_hs) begin
            awready_o <= 1'b0;
            wr_st     <= 2'd1;
          end else begin
            awready_o <= 1'($urandom % 2);
          end
        end
        2'd1: begin
          if (w_hs) begin
            wready_o <= 1'b0;
            // A rejected write leaves memory untouched
            if (!(err_en_i && aw_addr_q == err_addr_i)) mem[aw_addr_q[9:2]] <= w_data_q;
            wr_cnt <= 2'($urandom % 3);
            wr_st  <= 2'd2;
          end else begin
            wready_o <= 1'($urandom % 2);
          end
        end
        2'd2: begin
          if (wr_cnt == 2'd0) begin
            bvalid_o <= 1'b1;
            bresp_o  <= (err_en_i && aw_addr_q == err_addr_i) ? 2'b10 : 2'b00;
            wr_st    <= 2'd3;
          end else begin
            wr_cnt <= wr_cnt - 2'd1;
          end
        end
        default: begin
          if (b_hs) begin
            bvalid_o <= 1'b0;
            wr_st    <= 2'd0;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verification/dma_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dma_engine_tb import dma_pkg::*; ();

  typedef struct packed {
    logic        dir;
    logic [31:0] addr;
    logic [31:0] len;
    logic [3:0]  bsize;
    logic        incr;
    logic        err_en;
    logic [31:0] err_word;
  } row_t;

  localparam int NROWS = 8;

  logic clk, resetn, dma_en, dma_dir, incr_addr;
  logic [BURST_W-1:0] burst_size;
  logic [ADDR_W-1:0]  dma_addr, dma_len, err_addr;
  logic [LEVEL_W-1:0] tx_level, rx_level;
  logic [DATA_W-1:0]  fifo_tx_data, fifo_rx_data, wdata, rdata;
  logic fifo_tx_we, fifo_rx_re, dma_done, axi_err, busy, err_en;
  logic [ADDR_W-1:0]  awaddr, araddr;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [1:0] bresp, rresp;

  row_t        rows [NROWS];
  logic [31:0] tx_log[$];
  logic [31:0] ar_log[$];
  logic [31:0] aw_log[$];
  logic        tx_push, rx_pop;
  int          errors, cycles, limit, done_cnt, rx_pops;
  int          tx_lvl, rx_left, rx_idx, cur_row;

  dma_engine DUT (
    .clk(clk), .resetn(resetn), .dma_en_i(dma_en), .dma_dir_i(dma_dir),
    .burst_size_i(burst_size), .incr_addr_i(incr_addr), .dma_addr_i(dma_addr),
    .dma_len_i(dma_len), .tx_level_i(tx_level), .fifo_tx_data_o(fifo_tx_data),
    .fifo_tx_we_o(fifo_tx_we), .rx_level_i(rx_level), .fifo_rx_data_i(fifo_rx_data),
    .fifo_rx_re_o(fifo_rx_re), .dma_done_o(dma_done), .axi_err_o(axi_err),
    .busy_o(busy), .awaddr_o(awaddr), .awvalid_o(awvalid), .awready_i(awready),
    .wdata_o(wdata), .wvalid_o(wvalid), .wready_i(wready), .bvalid_i(bvalid),
    .bresp_i(bresp), .bready_o(bready), .araddr_o(araddr), .arvalid_o(arvalid),
    .arready_i(arready), .rdata_i(rdata), .rvalid_i(rvalid), .rresp_i(rresp),
    .rready_o(rready)
  );

  tb_axi_mem u_mem (
    .clk(clk), .resetn(resetn), .err_en_i(err_en), .err_addr_i(err_addr),
    .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
    .wdata_i(wdata), .wvalid_i(wvalid), .wready_o(wready),
    .bvalid_o(bvalid), .bresp_o(bresp), .bready_i(bready),
    .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
    .rdata_o(rdata), .rvalid_o(rvalid), .rresp_o(rresp), .rready_i(rready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return (addr * 32'h9e3779b1) ^ 32'h5a5ac3c3;
  endfunction

  function automatic logic [31:0] rx_word(input int row, input int k);
    return 32'hc0de0000 | (32'(row) << 8) | 32'(k);
  endfunction

  function automatic logic [31:0] word_addr(input row_t rw, input int k);
    return rw.incr ? rw.addr + 32'(k) * 32'd4 : rw.addr;
  endfunction

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // ------------------------------
  // Monitors and FIFO models
  // ------------------------------
  always @(posedge clk) begin
    tx_push <= fifo_tx_we;
    rx_pop  <= fifo_rx_re;
    if (fifo_tx_we) tx_log.push_back(fifo_tx_data);
    if (fifo_rx_re) rx_pops++;
    if (arvalid && arready) ar_log.push_back(araddr);
    if (awvalid && awready) aw_log.push_back(awaddr);
    if (dma_done) done_cnt++;
    cycles++;
    if (cycles >= limit) begin
      $display("Timeout: the DUT did not finish the table within %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (tx_push) tx_lvl++;
    // TX side drains at random
    if (tx_lvl > 0 && ($urandom % 3) == 0) tx_lvl--;
    tx_level <= LEVEL_W'(tx_lvl);
    if (rx_pop) begin
      fifo_rx_data <= rx_word(cur_row, rx_idx);
      rx_idx++;
      rx_left--;
    end
    rx_level <= LEVEL_W'(rx_left);
  end

  task automatic run_row(input int r);
    row_t        rw;
    int          words, bw, exp_n;
    logic [31:0] a;
    logic [31:0] snap [256];
    rw    = rows[r];
    words = int'(rw.len >> 2);
    bw    = (rw.bsize == 4'd0) ? 1 : int'(rw.bsize);
    exp_n = words;
    if (rw.err_en) begin
      exp_n = (int'(rw.err_word) / bw + 1) * bw;
      if (exp_n > words) exp_n = words;
    end
    for (int i = 0; i < 256; i++) snap[i] = u_mem.mem[i];
    tx_log.delete();
    ar_log.delete();
    aw_log.delete();
    done_cnt   = 0;
    rx_pops    = 0;
    cur_row    = r;
    rx_idx     = 0;
    rx_left    = rw.dir ? words : 0;
    dma_dir    = rw.dir;
    dma_addr   = rw.addr;
    dma_len    = rw.len;
    burst_size = rw.bsize;
    incr_addr  = rw.incr;
    err_en     = rw.err_en;
    err_addr   = rw.addr + (rw.err_word << 2);
    @(negedge clk);
    dma_en = 1'b1;
    @(negedge clk);
    while (!dma_done) begin
      check_hex("busy_o", 32'(busy), 32'd1);
      @(negedge clk);
    end
    check_hex("busy_o", 32'(busy), 32'd0);
    check_hex("axi_err_o", 32'(axi_err), 32'(rw.err_en));
    dma_en = 1'b0;
    repeat (4) @(negedge clk);
    check_hex("dma_done_o pulses", 32'(done_cnt), 32'd1);
    check_hex("axi_err_o", 32'(axi_err), 32'd0);
    if (!rw.dir) begin
      check_hex("fifo_tx_we_o count", 32'(tx_log.size()), 32'(exp_n));
      check_hex("arvalid_o count", 32'(ar_log.size()), 32'(exp_n));
      check_hex("awvalid_o count", 32'(aw_log.size()), 32'd0);
      check_hex("fifo_rx_re_o count", 32'(rx_pops), 32'd0);
      for (int k = 0; k < exp_n && k < tx_log.size() && k < ar_log.size(); k++) begin
        a = word_addr(rw, k);
        check_hex("fifo_tx_data_o", tx_log[k], expected_word(a));
        check_hex("araddr_o", ar_log[k], a);
      end
    end else begin
      check_hex("fifo_rx_re_o count", 32'(rx_pops), 32'(exp_n));
      check_hex("awvalid_o count", 32'(aw_log.size()), 32'(exp_n));
      check_hex("arvalid_o count", 32'(ar_log.size()), 32'd0);
      check_hex("fifo_tx_we_o count", 32'(tx_log.size()), 32'd0);
      for (int k = 0; k < exp_n; k++) begin
        a = word_addr(rw, k);
        if (k < aw_log.size()) check_hex("awaddr_o", aw_log[k], a);
        if (!(rw.err_en && 32'(k) == rw.err_word)) snap[a[9:2]] = rx_word(r, k);
      end
      for (int i = 0; i < 256; i++) begin
        check_hex($sformatf("mem[%0d]", i), u_mem.mem[i], snap[i]);
      end
    end
  endtask

  initial begin
    int total;
    void'($urandom(32'h6da4fc4f));
    //          dir   addr        len     bsize incr  err   err word
    rows[0] = '{1'b0, 32'h040, 32'd40, 4'd4,  1'b1, 1'b0, 32'd0};
    rows[1] = '{1'b1, 32'h100, 32'd24, 4'd0,  1'b1, 1'b0, 32'd0};
    rows[2] = '{1'b0, 32'h080, 32'd0,  4'd2,  1'b1, 1'b0, 32'd0};
    rows[3] = '{1'b0, 32'h020, 32'd16, 4'd3,  1'b0, 1'b0, 32'd0};
    rows[4] = '{1'b1, 32'h200, 32'd12, 4'd2,  1'b0, 1'b0, 32'd0};
    rows[5] = '{1'b0, 32'h000, 32'd48, 4'd4,  1'b1, 1'b1, 32'd5};
    rows[6] = '{1'b1, 32'h300, 32'd32, 4'd3,  1'b1, 1'b1, 32'd2};
    rows[7] = '{1'b0, 32'h180, 32'd64, 4'd15, 1'b1, 1'b0, 32'd0};
    total = 0;
    for (int r = 0; r < NROWS; r++) total += int'(rows[r].len >> 2);
    limit   = total * 40 + 200;
    cycles  = 0;
    errors  = 0;
    tx_push = 1'b0;
    rx_pop  = 1'b0;
    tx_lvl  = 0;
    rx_left = 0;
    rx_idx  = 0;
    cur_row = 0;
    {resetn, dma_en, dma_dir, incr_addr, err_en} = '0;
    burst_size   = '0;
    dma_addr     = '0;
    dma_len      = '0;
    err_addr     = '0;
    tx_level     = '0;
    rx_level     = '0;
    fifo_rx_data = '0;
    repeat (2) @(negedge clk);
    resetn = 1'b1;
    @(negedge clk);
    // Quiet outputs out of reset
    check_hex("awvalid_o", 32'(awvalid), 32'd0);
    check_hex("wvalid_o", 32'(wvalid), 32'd0);
    check_hex("bready_o", 32'(bready), 32'd0);
    check_hex("arvalid_o", 32'(arvalid), 32'd0);
    check_hex("rready_o", 32'(rready), 32'd0);
    check_hex("fifo_tx_we_o", 32'(fifo_tx_we), 32'd0);
    check_hex("fifo_rx_re_o", 32'(fifo_rx_re), 32'd0);
    check_hex("busy_o", 32'(busy), 32'd0);
    check_hex("axi_err_o", 32'(axi_err), 32'd0);
    check_hex("dma_done_o", 32'(dma_done), 32'd0);
    for (int r = 0; r < NROWS; r++) run_row(r);
    $display("Finished %0d rows with %0d errors", NROWS, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
verilog/dma_pkg.sv
verilog/dma_burst_if.sv
verilog/dma_ctrl_fsm.sv
verilog/dma_xfer_counter.sv
verilog/axi_rd_mover.sv
verilog/axi_wr_mover.sv
verilog/dma_engine.sv
verification/tb_axi_mem.sv
verification/dma_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f sources.f --top-module dma_engine_tb -o dma_engine_sim \
  && ./obj_dir/dma_engine_sim > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "TEST OK" sim.log || { echo "No pass message in the log"; exit 1; }
exit 0
